// File: hw/board_pkg.sv
package board_pkg;

    // bus widths
    localparam int data_wid = 32;   // address and data words
    localparam int led_wid  = 8;    // one led bank, also seg_en and seg_out
    localparam int kp_wid   = 16;   // keypad lines

    // one received uart byte
    typedef logic [7:0] byte_t;

    // a single loader write, address sits in the upper word
    typedef struct packed {
        logic [data_wid-1:0] addr;
        logic [data_wid-1:0] data;
    } wr_t;

    // debounced keypad state
    typedef struct packed {
        logic       valid;  // some line pressed
        logic [3:0] idx;    // lowest pressed line
    } key_t;

    // register map
    localparam logic [data_wid-1:0] addr_led1 = 32'd0;
    localparam logic [data_wid-1:0] addr_led2 = 32'd1;
    localparam logic [data_wid-1:0] addr_seg  = 32'd2;

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
    parameter int clks_per_bit = 868
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rx,
    output board_pkg::byte_t rx_byte,
    output logic             rx_done
);

    import board_pkg::*;

    localparam int cnt_wid = $clog2(clks_per_bit + 1);
    localparam logic [cnt_wid-1:0] bit_last = cnt_wid'(clks_per_bit - 1);
    localparam logic [cnt_wid-1:0] half_bit = cnt_wid'((clks_per_bit - 1) / 2);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t             state;
    logic [2:0]         rx_sync;    // [1] is the clean line, [2] its previous value
    logic               fall;
    logic               sample;
    logic [cnt_wid-1:0] cyc_cnt;
    logic [2:0]         bit_cnt;
    byte_t              shift_q;

    // synchronizer plus one flop for edge detect, line idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 3'b111;
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
        end
    end

    assign fall   = rx_sync[2] & ~rx_sync[1];
    assign sample = (cyc_cnt == bit_last);  // mid-bit once aligned by the start state

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            unique case (state)
                st_idle: begin
                    cyc_cnt <= '0;
                    bit_cnt <= '0;
                    if (fall) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (cyc_cnt == half_bit) begin
                        cyc_cnt <= '0;
                        state   <= rx_sync[1] ? st_idle : st_data;  // high again means glitch
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (sample) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (sample) begin
                        cyc_cnt <= '0;
                        rx_done <= rx_sync[1];  // low stop bit drops the byte
                        state   <= st_idle;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == st_data && sample) begin
            shift_q <= {rx_sync[1], shift_q[7:1]};
        end
    end

    assign rx_byte = shift_q;

    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        rx_done |=> !rx_done
    );

endmodule

// File: hw/uart_loader.sv
`timescale 1ns/1ns

module uart_loader (
    input  logic             clk,
    input  logic             rst_n,
    input  board_pkg::byte_t rx_byte,
    input  logic             rx_done,
    output board_pkg::wr_t   wr,
    output logic             wr_done
);

    import board_pkg::*;

    localparam int wr_bits     = $bits(wr_t);
    localparam int byte_bits   = $bits(byte_t);
    localparam int frame_bytes = wr_bits / byte_bits;   // 4 address + 4 data
    localparam int cnt_wid     = $clog2(frame_bytes);
    localparam logic [cnt_wid-1:0] last_byte = cnt_wid'(frame_bytes - 1);

    logic [cnt_wid-1:0] byte_cnt;
    logic [wr_bits-1:0] asm_q;  // msb first, so the first byte ends up on top

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            wr_done  <= 1'b0;
        end else begin
            wr_done <= rx_done && (byte_cnt == last_byte);
            if (rx_done) begin
                // wrap after every frame
                byte_cnt <= (byte_cnt == last_byte) ? '0 : byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            asm_q <= {asm_q[wr_bits-byte_bits-1:0], rx_byte};
        end
    end

    // asm_q holds the whole frame while wr_done is high
    assign wr = asm_q;

    a_wr_after_byte: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_done |-> $past(rx_done)
    );

endmodule

// File: hw/keypad_decode.sv
`timescale 1ns/1ns

module keypad_decode #(
    parameter int debounce_cycles = 100000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [board_pkg::kp_wid-1:0] kp,
    output board_pkg::key_t             key
);

    import board_pkg::*;

    localparam int cnt_wid = $clog2(debounce_cycles + 1);
    localparam logic [cnt_wid-1:0] stable_max = cnt_wid'(debounce_cycles);

    logic [kp_wid-1:0]  kp_meta;
    logic [kp_wid-1:0]  kp_sync;
    key_t               cand;
    key_t               cand_q;     // candidate being timed
    logic [cnt_wid-1:0] stable_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kp_meta <= '0;
            kp_sync <= '0;
        end else begin
            kp_meta <= kp;
            kp_sync <= kp_meta;
        end
    end

    // scan downward so the lowest pressed line wins
    always_comb begin
        cand = '0;
        for (int i = kp_wid - 1; i >= 0; i--) begin
            if (kp_sync[i]) begin
                cand.valid = 1'b1;
                cand.idx   = 4'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cand_q     <= '0;
            stable_cnt <= '0;
            key        <= '0;
        end else if (cand != cand_q) begin
            cand_q     <= cand;
            stable_cnt <= '0;   // restart timing on any change
        end else if (stable_cnt != stable_max) begin
            stable_cnt <= stable_cnt + 1'b1;
        end else begin
            key <= cand_q;
        end
    end

endmodule

// File: hw/io_regs.sv
`timescale 1ns/1ns

module io_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  board_pkg::wr_t                 wr,
    input  logic                           wr_done,
    input  board_pkg::key_t                key,
    output logic [board_pkg::led_wid-1:0]  led1_out,
    output logic [board_pkg::led_wid-1:0]  led2_out,
    output logic [board_pkg::led_wid-1:0]  led3_out,
    output logic [board_pkg::data_wid-1:0] seg_value
);

    import board_pkg::*;

    localparam int key_bits = $bits(key_t);

    // writable registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led1_out  <= '0;
            led2_out  <= '0;
            seg_value <= '0;
        end else if (wr_done) begin
            case (wr.addr)
                addr_led1: led1_out  <= wr.data[led_wid-1:0];
                addr_led2: led2_out  <= wr.data[led_wid-1:0];
                addr_seg:  seg_value <= wr.data;
                default: begin
                    // unmapped address, nothing changes
                end
            endcase
        end
    end

    // key state on bank 3: valid in bit 4, index below
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led3_out <= '0;
        end else begin
            led3_out <= {{(led_wid - key_bits){1'b0}}, key};
        end
    end

endmodule

// File: hw/seg7_scan.sv
`timescale 1ns/1ns

module seg7_scan #(
    parameter int scan_cycles = 50000
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [board_pkg::data_wid-1:0] seg_value,
    output logic [board_pkg::led_wid-1:0]  seg_en,
    output logic [board_pkg::led_wid-1:0]  seg_out
);

    import board_pkg::*;

    localparam int cnt_wid = $clog2(scan_cycles + 1);
    localparam logic [cnt_wid-1:0] dwell_last = cnt_wid'(scan_cycles - 1);

    logic [cnt_wid-1:0] dwell_cnt;
    logic [2:0]         digit;
    logic               scanning;   // set at the first scan step
    logic [3:0]         nibble;

    // active-high segments, bit 0 is a, bit 6 is g
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        logic [6:0] pat;
        case (hex)
            4'h0: pat = 7'h3f;
            4'h1: pat = 7'h06;
            4'h2: pat = 7'h5b;
            4'h3: pat = 7'h4f;
            4'h4: pat = 7'h66;
            4'h5: pat = 7'h6d;
            4'h6: pat = 7'h7d;
            4'h7: pat = 7'h07;
            4'h8: pat = 7'h7f;
            4'h9: pat = 7'h6f;
            4'ha: pat = 7'h77;
            4'hb: pat = 7'h7c;
            4'hc: pat = 7'h39;
            4'hd: pat = 7'h5e;
            4'he: pat = 7'h79;
            default: pat = 7'h71;
        endcase
        return pat;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            digit     <= '0;
            scanning  <= 1'b0;
        end else if (dwell_cnt == dwell_last) begin
            dwell_cnt <= '0;
            scanning  <= 1'b1;
            if (scanning) begin
                digit <= digit + 1'b1;  // wraps 7 -> 0
            end
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    assign nibble = seg_value[{digit, 2'b00} +: 4];

    // everything active low, decimal point kept dark
    assign seg_en  = scanning ? ~(led_wid'(1) << digit) : '1;
    assign seg_out = {1'b1, ~hex_to_seg(nibble)};

    a_one_digit: assert property (
        @(posedge clk) disable iff (!rst_n)
        scanning |-> $onehot(~seg_en)
    );

endmodule

// File: hw/board_top.sv
`timescale 1ns/1ns

module board_top #(
    parameter int clks_per_bit    = 868,
    parameter int debounce_cycles = 100000,
    parameter int scan_cycles     = 50000
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rx,
    input  logic [board_pkg::kp_wid-1:0]  kp,
    output logic [board_pkg::led_wid-1:0] led1_out,
    output logic [board_pkg::led_wid-1:0] led2_out,
    output logic [board_pkg::led_wid-1:0] led3_out,
    output logic [board_pkg::led_wid-1:0] seg_en,
    output logic [board_pkg::led_wid-1:0] seg_out
);

    import board_pkg::*;

    byte_t               rx_byte;
    logic                rx_done;
    wr_t                 wr;
    logic                wr_done;
    key_t                key;
    logic [data_wid-1:0] seg_value;

    uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_inst (
        .clk,
        .rst_n,
        .rx,
        .rx_byte,
        .rx_done
    );

    uart_loader uart_loader_inst (
        .clk,
        .rst_n,
        .rx_byte,
        .rx_done,
        .wr,
        .wr_done
    );

    keypad_decode #(.debounce_cycles(debounce_cycles)) keypad_inst (
        .clk,
        .rst_n,
        .kp,
        .key
    );

    // stands in for the cpu's memory-mapped io
    io_regs io_regs_inst (
        .clk,
        .rst_n,
        .wr,
        .wr_done,
        .key,
        .led1_out,
        .led2_out,
        .led3_out,
        .seg_value
    );

    seg7_scan #(.scan_cycles(scan_cycles)) seg7_inst (
        .clk,
        .rst_n,
        .seg_value,
        .seg_en,
        .seg_out
    );

endmodule

// File: tb/board_tb.sv
`timescale 1ns/1ns

module board_tb;

    import board_pkg::*;

    localparam int clks_per_bit    = 8;
    localparam int debounce_cycles = 16;
    localparam int scan_cycles     = 4;
    localparam int frame_cycles    = 8 * 10 * clks_per_bit;    // eight bytes of ten bits
    localparam int timeout_cycles  = 9 * frame_cycles + 240;   // frames plus keypad and waits

    logic               clk;
    logic               rst_n;
    logic               rx;
    logic [kp_wid-1:0]  kp;
    logic [led_wid-1:0] led1_out;
    logic [led_wid-1:0] led2_out;
    logic [led_wid-1:0] led3_out;
    logic [led_wid-1:0] seg_en;
    logic [led_wid-1:0] seg_out;

    string       cur_test;
    int          err_count   = 0;
    int          test_count  = 0;
    int          fail_count  = 0;
    int          errs_at_start;
    int          cycle_count = 0;
    logic        scan_seen;
    logic        disp_chk;          // display check window
    logic [31:0] disp_word;

    board_top #(
        .clks_per_bit   (clks_per_bit),
        .debounce_cycles(debounce_cycles),
        .scan_cycles    (scan_cycles)
    ) dut (
        .clk,
        .rst_n,
        .rx,
        .kp,
        .led1_out,
        .led2_out,
        .led3_out,
        .seg_en,
        .seg_out
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // first digit lit means scanning is under way
    always @(posedge clk) begin
        if (!rst_n) begin
            scan_seen <= 1'b0;
        end else if (seg_en != '1) begin
            scan_seen <= 1'b1;
        end
    end

    // segments a..g in bits 0..6, active high
    function automatic logic [6:0] seg_pattern(input logic [3:0] hex);
        logic [6:0] pat;
        case (hex)
            4'h0: pat = 7'h3f;
            4'h1: pat = 7'h06;
            4'h2: pat = 7'h5b;
            4'h3: pat = 7'h4f;
            4'h4: pat = 7'h66;
            4'h5: pat = 7'h6d;
            4'h6: pat = 7'h7d;
            4'h7: pat = 7'h07;
            4'h8: pat = 7'h7f;
            4'h9: pat = 7'h6f;
            4'ha: pat = 7'h77;
            4'hb: pat = 7'h7c;
            4'hc: pat = 7'h39;
            4'hd: pat = 7'h5e;
            4'he: pat = 7'h79;
            default: pat = 7'h71;
        endcase
        return pat;
    endfunction

    // active-low pattern for whichever digit seg_en selects
    function automatic logic [7:0] expected_seg(input logic [7:0] en, input logic [31:0] word);
        logic [7:0] result;
        result = 8'hff;
        for (int i = 0; i < 8; i++) begin
            if (!en[i]) begin
                result = {1'b1, ~seg_pattern(word[4*i +: 4])};  // dp stays dark
            end
        end
        return result;
    endfunction

    a_scan_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan_seen |-> $onehot(~seg_en)
    ) else begin
        $display("%s: seg_en %b does not select exactly one digit", cur_test, $sampled(seg_en));
        err_count++;
    end

    a_seg_pattern: assert property (
        @(posedge clk) disable iff (!rst_n)
        disp_chk |-> seg_out == expected_seg(seg_en, disp_word)
    ) else begin
        $display("error %s: seg_out expected %h actual %h", cur_test,
                 expected_seg($sampled(seg_en), $sampled(disp_word)), $sampled(seg_out));
        err_count++;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic hold_bit(input logic v);
        rx = v;
        wait_cycles(clks_per_bit);
    endtask

    task automatic send_byte(input logic [7:0] b, input logic stop_bit);
        hold_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            hold_bit(b[i]);     // lsb first
        end
        hold_bit(stop_bit);
        if (!stop_bit) begin
            hold_bit(1'b1);     // line must rise before the next start bit
        end
    endtask

    task automatic send_frame(input logic [31:0] addr, input logic [31:0] data);
        logic [63:0] frame;
        frame = {addr, data};
        for (int i = 7; i >= 0; i--) begin
            send_byte(frame[8*i +: 8], 1'b1);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    // 32 cycles visits all eight digits
    task automatic check_display(input logic [31:0] word);
        disp_word = word;
        disp_chk  = 1'b1;
        wait_cycles(32);
        disp_chk  = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = err_count;
        test_count++;
    endtask

    task automatic end_test();
        if (err_count == errs_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, err_count - errs_at_start);
            fail_count++;
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] seg_word;
        logic [7:0]  led1_exp;
        logic [7:0]  led2_exp;
        clk       = 1'b0;
        rst_n     = 1'b0;
        rx        = 1'b1;   // idle line
        kp        = '0;
        disp_chk  = 1'b0;
        disp_word = '0;
        cur_test  = "reset";
        data      = $urandom(32'h9c4e_44c3);   // seed once
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test("reset");
        check_value("led1_out", 32'h0, led1_out);
        check_value("led2_out", 32'h0, led2_out);
        check_value("led3_out", 32'h0, led3_out);
        end_test();

        begin_test("led_write");
        data     = $urandom();
        led1_exp = data[7:0];
        send_frame(addr_led1, data);
        wait_cycles(20);
        check_value("led1_out", led1_exp, led1_out);
        check_value("led2_out", 32'h0, led2_out);
        data     = $urandom();
        led2_exp = data[7:0];
        send_frame(addr_led2, data);
        wait_cycles(20);
        check_value("led2_out", led2_exp, led2_out);
        check_value("led1_out", led1_exp, led1_out);
        end_test();

        begin_test("display");
        seg_word = $urandom();
        send_frame(addr_seg, seg_word);
        wait_cycles(20);
        check_display(seg_word);
        end_test();

        begin_test("unmapped");
        send_frame(32'd7, $urandom());
        wait_cycles(20);
        check_value("led1_out", led1_exp, led1_out);
        check_value("led2_out", led2_exp, led2_out);
        check_value("led3_out", 32'h0, led3_out);
        check_display(seg_word);    // display keeps the old word
        end_test();

        begin_test("bad_stop");
        send_byte(8'ha5, 1'b0);
        data     = $urandom();
        led1_exp = data[7:0];
        send_frame(addr_led1, data);
        wait_cycles(20);
        check_value("led1_out", led1_exp, led1_out);
        check_value("led2_out", led2_exp, led2_out);
        end_test();

        begin_test("keypad");
        kp    = '0;
        kp[5] = 1'b1;
        kp[9] = 1'b1;   // lowest line wins
        wait_cycles(40);
        check_value("led3_out", {27'h0, 1'b1, 4'd5}, led3_out);
        kp = '0;
        wait_cycles(40);
        check_value("led3_out", 32'h0, led3_out);
        kp[2] = 1'b1;
        for (int i = 0; i < 48; i++) begin
            if (i == 8) begin
                kp = '0;    // released before the debounce time
            end
            wait_cycles(1);
            check_value("led3_out", 32'h0, led3_out);
        end
        end_test();

        wait_cycles(4);
        $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/board_pkg.sv
hw/uart_rx.sv
hw/uart_loader.sv
hw/keypad_decode.sv
hw/io_regs.sv
hw/seg7_scan.sv
hw/board_top.sv
tb/board_tb.sv
